// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - rtl/rv_exec_pkg.sv
  - rtl/rv_decode.sv
  - rtl/rv_issue_reg.sv
  - rtl/rv_alu.sv
  - rtl/rv_exec_top.sv
  - target: any(simulation, test)
    files:
      - verification/rv_exec_properties.sv
      - verification/rv_exec_tb.sv

// ==== rtl/rv_alu.sv ====
// alu: operand mux, invertible adder, logic unit, shifter and registered result
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire  rv_exec_pkg::issue_t issue,
  output rv_exec_pkg::xlen_t       fwd_rd,   // unregistered rd
  output rv_exec_pkg::result_t     result
);

  import rv_exec_pkg::*;

  logic   sgn;   // sign extend arithmetic operands
  logic   inv;   // invert operand 2
  xlen_t  in1;   // multiplexed input 1
  xlen_t  in2;   // multiplexed input 2
  sum_t   ao1;   // arithmetic operand 1, one bit wider
  sum_t   ao2;
  sum_t   sum;
  xlen_t  lo1;   // logical operands
  xlen_t  lo2;
  shamt_t sa;    // shift amount
  xlen_t  rd;

  // one bit extension, signed or unsigned
  function automatic sum_t extend(input xlen_t val, input logic sgn_ext);
    extend = sgn_ext ? {val[XLEN-1], val} : {1'b0, val};
  endfunction

  ////////////////////////////////////////////////////////////
  // arithmetic
  ////////////////////////////////////////////////////////////

  assign sgn = (issue.ctl.op != AO_SLTU);   // address and auipc forms stay signed

  always_comb begin
    unique case (issue.ctl.ai)
      AI_R1_R2: begin in1 = issue.rs1; in2 = issue.rs2;     end
      AI_R1_II,
      AI_R1_IL,
      AI_R1_IS: begin in1 = issue.rs1; in2 = issue.ctl.imm; end  // imm format set by decode
      AI_PC_IU: begin in1 = issue.pc;  in2 = issue.ctl.imm; end
      default:  begin in1 = '0;        in2 = '0;            end
    endcase
  end

  assign ao1 = extend(in1, sgn);
  assign ao2 = extend(in2, sgn);

  always_comb begin
    unique case (issue.ctl.op)
      AO_SUB,
      AO_SLT,
      AO_SLTU: inv = 1'b1;
      default: inv = 1'b0;
    endcase
  end

  // subtract as a + ~b + 1
  assign sum = ao1 + (inv ? ~ao2 : ao2) + sum_t'(inv);

  ////////////////////////////////////////////////////////////
  // logic and shift
  ////////////////////////////////////////////////////////////

  // shared with the adder mux
  assign lo1 = ao1[XLEN-1:0];
  assign lo2 = ao2[XLEN-1:0];

  // immediate shamt for op-imm, rs2 low bits otherwise
  assign sa = (issue.ctl.ai == AI_R1_II) ? issue.ctl.imm[SHAMT_W-1:0]
                                         : issue.rs2[SHAMT_W-1:0];

  ////////////////////////////////////////////////////////////
  // output mux and result stage
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (issue.ctl.op)
      AO_ADD,
      AO_SUB:  rd = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: rd = xlen_t'(sum[XLEN]);       // sign of the wide difference
      AO_AND:  rd = lo1 & lo2;
      AO_OR:   rd = lo1 | lo2;
      AO_XOR:  rd = lo1 ^ lo2;
      AO_SRA:  rd = xlen_t'($signed(issue.rs1) >>> sa);
      AO_SRL:  rd = issue.rs1 >> sa;
      AO_SLL:  rd = issue.rs1 << sa;
      default: rd = '0;
    endcase
  end

  assign fwd_rd = rd;  // back to the issue register

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result.valid   <= issue.valid;
      result.rd_addr <= issue.ctl.rd_addr;
      result.wen     <= issue.valid && issue.ctl.wen;   // idle slots never write
      result.illegal <= issue.valid && issue.ctl.illegal;
      result.rd      <= rd;
      result.sum     <= sum;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_decode.sv ====
// rv32i decoder: instruction word to alu control struct with selected immediate
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire rv_exec_pkg::instr_t instr,
  output rv_exec_pkg::ctl_t        ctl
);

  import rv_exec_pkg::*;

  opcode_e    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  xlen_t      imm_i;   // i-type, also load offset
  xlen_t      imm_s;   // store offset
  xlen_t      imm_u;   // upper immediate
  logic       writes;  // format has an rd

  ////////////////////////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////////////////////////

  assign opc = opcode_e'(instr[6:0]);
  assign f3  = instr[14:12];
  assign f7  = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctl          = '0;           // add, r1/r2, no write
    ctl.rd_addr  = instr[11:7];
    ctl.rs1_addr = instr[19:15];
    ctl.rs2_addr = instr[24:20];
    writes       = 1'b0;

    unique case (opc)
      OPC_OP: begin
        ctl.ai = AI_R1_R2;
        ctl.op = alu_op_e'({f7[5], f3});
        writes = 1'b1;
        // only sub and sra use the alternate funct7
        if (f7 == F7_ALT) begin
          ctl.illegal = !((f3 == F3_ADD) || (f3 == F3_SR));
        end else begin
          ctl.illegal = (f7 != F7_BASE);
        end
      end
      OPC_OP_IMM: begin
        ctl.ai  = AI_R1_II;
        ctl.imm = imm_i;
        writes  = 1'b1;
        if (f3 == F3_SR) begin
          ctl.op      = alu_op_e'({f7[5], f3});  // srli / srai
          ctl.illegal = (f7 != F7_BASE) && (f7 != F7_ALT);
        end else if (f3 == F3_SLL) begin
          ctl.op      = AO_SLL;
          ctl.illegal = (f7 != F7_BASE);
        end else begin
          ctl.op = alu_op_e'({1'b0, f3});  // bit 30 is immediate here
        end
      end
      OPC_LOAD: begin
        ctl.ai  = AI_R1_IL;   // address only, no rd write here
        ctl.imm = imm_i;
        ctl.op  = AO_ADD;
      end
      OPC_STORE: begin
        ctl.ai  = AI_R1_IS;
        ctl.imm = imm_s;
        ctl.op  = AO_ADD;
      end
      OPC_AUIPC: begin
        ctl.ai  = AI_PC_IU;
        ctl.imm = imm_u;
        ctl.op  = AO_ADD;
        writes  = 1'b1;
      end
      default: begin
        ctl.illegal = 1'b1;   // unknown major opcode
      end
    endcase

    // x0 writes are dropped here so forwarding never matches x0
    ctl.wen = writes && (ctl.rd_addr != '0) && !ctl.illegal;
  end

endmodule

`default_nettype wire

// ==== rtl/rv_exec_pkg.sv ====
// rv32i execute slice: shared widths, control encodings and pipeline structs
`default_nettype none

package rv_exec_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN    = 32;             // data path width
  localparam int unsigned ILEN    = 32;             // instruction word
  localparam int unsigned REG_AW  = 5;              // register index bits
  localparam int unsigned SHAMT_W = $clog2(XLEN);   // barrel shifter range

  // funct3 / funct7 codes the decoder needs for legality
  localparam logic [2:0] F3_ADD  = 3'b000;   // add/sub
  localparam logic [2:0] F3_SLL  = 3'b001;   // shift left
  localparam logic [2:0] F3_SR   = 3'b101;   // shift right, logical or arith
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

  typedef logic [XLEN-1:0]    xlen_t;      // operand / result value
  typedef logic [XLEN:0]      sum_t;       // adder result with extension bit
  typedef logic [REG_AW-1:0]  reg_addr_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [ILEN-1:0]    instr_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // major opcodes handled by this slice
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // alu operation, laid out as {funct7[5], funct3}
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111,
    AO_SUB  = 4'b1000,
    AO_SRA  = 4'b1101
  } alu_op_e;

  // operand pair selection
  typedef enum logic [2:0] {
    AI_R1_R2 = 3'd0,   // r-type
    AI_R1_II = 3'd1,   // rs1, i immediate
    AI_R1_IL = 3'd2,   // rs1, load offset
    AI_R1_IS = 3'd3,   // rs1, store offset
    AI_PC_IU = 3'd4    // pc, u immediate
  } alu_in_e;

  ////////////////////////////////////////////////////////////
  // pipeline structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e   op;
    alu_in_e   ai;
    xlen_t     imm;        // sign extended, format already chosen
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      wen;        // writes rd, rd != x0
    logic      illegal;
  } ctl_t;

  typedef struct packed {
    logic  valid;
    ctl_t  ctl;
    xlen_t pc;
    xlen_t rs1;
    xlen_t rs2;
  } issue_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd_addr;
    logic      wen;
    logic      illegal;
    xlen_t     rd;
    sum_t      sum;        // top bit is the slt/sltu answer
  } result_t;

endpackage

`default_nettype wire

// ==== rtl/rv_exec_top.sv ====
// execute slice top: decoder, issue register and alu, two cycle latency
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          in_valid,
  input  wire  rv_exec_pkg::instr_t    instr,
  input  wire  rv_exec_pkg::xlen_t     pc,
  input  wire  rv_exec_pkg::xlen_t     rs1_val,
  input  wire  rv_exec_pkg::xlen_t     rs2_val,
  output logic                         out_valid,
  output logic                         out_wen,
  output logic                         out_illegal,
  output rv_exec_pkg::reg_addr_t       out_rd_addr,
  output rv_exec_pkg::xlen_t           out_rd,
  output rv_exec_pkg::sum_t            out_sum
);

  import rv_exec_pkg::*;

  ctl_t    ctl;      // decode -> issue
  issue_t  issue;    // issue -> alu
  xlen_t   fwd_rd;   // alu -> issue, forwarding path
  result_t result;

  rv_decode u_decode (
    .instr (instr),
    .ctl   (ctl)
  );

  rv_issue_reg u_issue (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .ctl      (ctl),
    .pc       (pc),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .fwd_rd   (fwd_rd),
    .issue    (issue)
  );

  rv_alu u_alu (
    .clk    (clk),
    .arst_n (arst_n),
    .issue  (issue),
    .fwd_rd (fwd_rd),
    .result (result)
  );

  // outputs straight from the result register
  assign out_valid   = result.valid;
  assign out_wen     = result.wen;
  assign out_illegal = result.illegal;
  assign out_rd_addr = result.rd_addr;
  assign out_rd      = result.rd;
  assign out_sum     = result.sum;

endmodule

`default_nettype wire

// ==== rtl/rv_issue_reg.sv ====
// issue register: one decoded instruction in flight, with forwarding of the alu result
`timescale 1ns/1ps
`default_nettype none

module rv_issue_reg (
  input  wire                      clk,
  input  wire                      arst_n,
  input  wire                      in_valid,
  input  wire  rv_exec_pkg::ctl_t  ctl,
  input  wire  rv_exec_pkg::xlen_t pc,
  input  wire  rv_exec_pkg::xlen_t rs1_val,
  input  wire  rv_exec_pkg::xlen_t rs2_val,
  input  wire  rv_exec_pkg::xlen_t fwd_rd,   // alu result of the held entry
  output rv_exec_pkg::issue_t      issue
);

  import rv_exec_pkg::*;

  logic  fwd_ok;    // held entry writes, incoming uses registers
  logic  hit_rs1;
  logic  hit_rs2;
  xlen_t rs1_sel;
  xlen_t rs2_sel;

  // hazard detect against the entry now in the alu
  assign fwd_ok  = issue.valid && issue.ctl.wen && (ctl.ai != AI_PC_IU);
  assign hit_rs1 = fwd_ok && (ctl.rs1_addr == issue.ctl.rd_addr);
  assign hit_rs2 = fwd_ok && (ctl.rs2_addr == issue.ctl.rd_addr);

  assign rs1_sel = hit_rs1 ? fwd_rd : rs1_val;  // regfile value is stale on a hit
  assign rs2_sel = hit_rs2 ? fwd_rd : rs2_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue <= '0;
    end else begin
      issue.valid <= in_valid;
      issue.ctl   <= ctl;
      issue.pc    <= pc;
      issue.rs1   <= rs1_sel;
      issue.rs2   <= rs2_sel;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/rv_exec_pkg.sv
rtl/rv_decode.sv
rtl/rv_issue_reg.sv
rtl/rv_alu.sv
rtl/rv_exec_top.sv
verification/rv_exec_properties.sv
verification/rv_exec_tb.sv

// ==== verification/rv_exec_properties.sv ====
// execute slice assertions: quiet reset, fixed latency, write enable legality
`timescale 1ns/1ps
`default_nettype none

module rv_exec_properties (
  input wire                         clk,
  input wire                         arst_n,
  input wire                         in_valid,
  input wire                         out_valid,
  input wire                         out_wen,
  input wire                         out_illegal,
  input wire rv_exec_pkg::reg_addr_t out_rd_addr
);

  int fail_cnt = 0;   // polled by the testbench

  // result register held clear in reset
  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      $error("out_valid high while arst_n is low");
      fail_cnt++;
    end

  // issue stage then result stage
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
                              out_valid == $past(in_valid, 2))
    else begin
      $error("out_valid does not follow in_valid by two cycles");
      fail_cnt++;
    end

  a_wen_legal: assert property (@(posedge clk) disable iff (!arst_n)
                                out_wen |-> (!out_illegal && (out_rd_addr != '0)))
    else begin
      $error("out_wen set with an illegal instruction or x0");
      fail_cnt++;
    end

endmodule

bind rv_exec_top rv_exec_properties u_props (
  .clk         (clk),
  .arst_n      (arst_n),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .out_wen     (out_wen),
  .out_illegal (out_illegal),
  .out_rd_addr (out_rd_addr)
);

`default_nettype wire

// ==== verification/rv_exec_tb.sv ====
// testbench for the rv32i execute slice: table stimulus, reference model, in order compare
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  import rv_exec_pkg::*;

  localparam int TIMEOUT = 20;   // cycles allowed per result

  typedef struct packed {
    instr_t     instr;
    xlen_t      pc;
    xlen_t      rs1;       // driven value, may be stale
    xlen_t      rs2;
    xlen_t      exp_rd;
    sum_t       exp_sum;
    logic       exp_wen;
    logic       exp_ill;
    logic [1:0] idle;      // idle cycles after this entry
  } vec_t;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  instr_t    instr;
  xlen_t     pc;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  logic      out_valid;
  logic      out_wen;
  logic      out_illegal;
  reg_addr_t out_rd_addr;
  xlen_t     out_rd;
  sum_t      out_sum;

  vec_t      tbl[$];
  string     names[$];
  int        sent_cyc[$];   // cycle count when each entry was driven
  int        cyc;
  integer    seed;
  logic      prev_wen;      // last entry writes and was back to back
  reg_addr_t prev_rd;
  xlen_t     prev_val;

  rv_exec_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // bound assertions count their failures
  always @(negedge clk) begin
    if (DUT.u_props.fail_cnt != 0) begin
      $display("a bound assertion on rv_exec_top failed");
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // encoders and reference model
  ////////////////////////////////////////////////////////////

  function automatic instr_t r_format(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t i_format(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_format(input logic [11:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic model(input instr_t w, input xlen_t pc_v, input xlen_t r1, input xlen_t r2,
                       output xlen_t rd, output sum_t sum, output logic wen, output logic ill);
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    sum_t       ea;
    sum_t       eb;
    shamt_t     sh;
    logic       alt;      // sub or sra
    logic       writes;
    f3     = w[14:12];
    f7     = w[31:25];
    a      = r1;
    b      = r2;
    sh     = r2[4:0];
    alt    = 1'b0;
    writes = 1'b1;
    ill    = 1'b0;
    case (w[6:0])
      7'b0110011: begin   // op
        alt = f7[5];
        ill = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
      end
      7'b0010011: begin   // op-imm, shamt lives in the immediate
        b   = {{20{w[31]}}, w[31:20]};
        sh  = w[24:20];
        alt = (f3 == 3'b101) && f7[5];
        ill = ((f3 == 3'b001) && (f7 != 7'h00)) ||
              ((f3 == 3'b101) && (f7 != 7'h00) && (f7 != 7'h20));
      end
      7'b0010111: begin   // auipc
        a  = pc_v;
        b  = {w[31:12], 12'b0};
        f3 = 3'b000;
      end
      7'b0000011: begin   // load address
        b      = {{20{w[31]}}, w[31:20]};
        f3     = 3'b000;
        writes = 1'b0;
      end
      7'b0100011: begin   // store address
        b      = {{20{w[31]}}, w[31:25], w[11:7]};
        f3     = 3'b000;
        writes = 1'b0;
      end
      default: begin
        ill    = 1'b1;
        writes = 1'b0;
      end
    endcase
    // extra top bit, zero only for sltu
    ea  = (f3 == 3'b011) ? {1'b0, a} : {a[31], a};
    eb  = (f3 == 3'b011) ? {1'b0, b} : {b[31], b};
    sum = ((f3 == 3'b000 && alt) || f3 == 3'b010 || f3 == 3'b011) ? ea - eb : ea + eb;
    case (f3)
      3'b000:  rd = sum[31:0];
      3'b001:  rd = a << sh;
      3'b010,
      3'b011:  rd = {31'b0, sum[32]};   // borrow out of the wide difference
      3'b100:  rd = a ^ b;
      3'b101:  rd = alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
      3'b110:  rd = a | b;
      default: rd = a & b;
    endcase
    wen = writes && !ill && (w[11:7] != 5'd0);
  endtask

  task automatic add_vec(input string name, input instr_t w, input xlen_t pc_v,
                         input xlen_t r1, input xlen_t r2, input int idle);
    vec_t  v;
    xlen_t a1;
    xlen_t a2;
    a1 = r1;
    a2 = r2;
    // back to back dependence, auipc reads no register
    if (prev_wen && (w[6:0] != 7'b0010111)) begin
      if (w[19:15] == prev_rd) a1 = prev_val;
      if (w[24:20] == prev_rd) a2 = prev_val;
    end
    v.instr = w;
    v.pc    = pc_v;
    v.rs1   = r1;
    v.rs2   = r2;
    v.idle  = idle[1:0];
    model(w, pc_v, a1, a2, v.exp_rd, v.exp_sum, v.exp_wen, v.exp_ill);
    tbl.push_back(v);
    names.push_back(name);
    prev_wen = v.exp_wen && (idle == 0);
    prev_rd  = w[11:7];
    prev_val = v.exp_rd;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  rd;
    reg_addr_t  ra;
    reg_addr_t  rb;
    add_vec("add", r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), '0, 32'h7fff_ffff, 32'h1, 1);
    add_vec("sub", r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), '0, 32'h5, 32'h7, 1);
    add_vec("and", r_format(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), '0, $random(seed), $random(seed), 1);
    add_vec("or", r_format(7'h00, 5'd2, 5'd1, 3'b110, 5'd5), '0, $random(seed), $random(seed), 1);
    add_vec("xor", r_format(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), '0, $random(seed), $random(seed), 1);
    add_vec("addi neg", i_format(12'hffb, 5'd1, 3'b000, 5'd6, 7'b0010011), '0, 32'h3, '0, 1);
    // -1 against 1, signed and unsigned disagree
    add_vec("slt", r_format(7'h00, 5'd2, 5'd1, 3'b010, 5'd7), '0, 32'hffff_ffff, 32'h1, 1);
    add_vec("sltu", r_format(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), '0, 32'hffff_ffff, 32'h1, 1);
    add_vec("slti", i_format(12'h001, 5'd1, 3'b010, 5'd7, 7'b0010011), '0, 32'hffff_ffff, '0, 1);
    // shifts
    add_vec("sll 0", r_format(7'h00, 5'd2, 5'd1, 3'b001, 5'd8), '0, 32'ha5a5_0f0f, 32'h0, 1);
    add_vec("srl 31", r_format(7'h00, 5'd2, 5'd1, 3'b101, 5'd8), '0, 32'h8000_0000, 32'd31, 1);
    add_vec("sra high rs2", r_format(7'h20, 5'd2, 5'd1, 3'b101, 5'd8), '0,
            32'h8000_0000, 32'hffff_ffe4, 1);
    add_vec("slli 31", i_format({7'h00, 5'd31}, 5'd1, 3'b001, 5'd8, 7'b0010011), '0, 32'h3, '0, 1);
    add_vec("srli 4", i_format({7'h00, 5'd4}, 5'd1, 3'b101, 5'd8, 7'b0010011), '0,
            32'hf000_00f0, '0, 1);
    add_vec("srai 31", i_format({7'h20, 5'd31}, 5'd1, 3'b101, 5'd8, 7'b0010011), '0,
            32'h8000_0001, '0, 1);
    // pc relative and address forms
    add_vec("auipc", {20'h12345, 5'd9, 7'b0010111}, 32'h1000, '0, '0, 1);
    add_vec("auipc neg", {20'hfffff, 5'd9, 7'b0010111}, 32'h10, '0, '0, 1);
    add_vec("load", i_format(12'hff0, 5'd2, 3'b010, 5'd10, 7'b0000011), '0, 32'h100, '0, 1);
    add_vec("store", s_format(12'h7fc, 5'd3, 5'd4), '0, 32'h2000, 32'h55, 1);
    // forwarding chain, stale values in the table
    add_vec("fwd producer", r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd11), '0, 32'd10, 32'd20, 0);
    add_vec("fwd rs1", r_format(7'h00, 5'd3, 5'd11, 3'b000, 5'd12), '0, 32'hdead_beef, 32'd5, 0);
    add_vec("fwd rs2", r_format(7'h20, 5'd12, 5'd4, 3'b000, 5'd13), '0, 32'd100, 32'hdead, 0);
    add_vec("fwd load", i_format(12'h004, 5'd13, 3'b010, 5'd14, 7'b0000011), '0, '0, '0, 1);
    add_vec("gap producer", i_format(12'h001, 5'd1, 3'b000, 5'd15, 7'b0010011), '0, 32'd7, '0, 1);
    add_vec("gap consumer", r_format(7'h00, 5'd2, 5'd15, 3'b000, 5'd16), '0, 32'h42, 32'h1, 0);
    add_vec("x0 producer", r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), '0, 32'd1, 32'd2, 0);
    add_vec("x0 consumer", r_format(7'h00, 5'd0, 5'd0, 3'b000, 5'd17), '0, 32'd9, 32'd4, 1);
    // legality
    add_vec("bad opcode", 32'h0000_0fff, '0, '0, '0, 1);
    add_vec("bad funct7", r_format(7'h01, 5'd2, 5'd1, 3'b000, 5'd5), '0, 32'd3, 32'd4, 1);
    // random r-type over x1..x4, frequent hazards
    for (int i = 0; i < 12; i++) begin
      f3 = $random(seed);
      f7 = (((f3 == 3'b000) || (f3 == 3'b101)) && ($random(seed) & 1)) ? 7'h20 : 7'h00;
      rd = 5'(1 + ($random(seed) & 3));
      ra = 5'(1 + ($random(seed) & 3));
      rb = 5'(1 + ($random(seed) & 3));
      add_vec($sformatf("random %0d", i), r_format(f7, rb, ra, f3, rd), '0,
              $random(seed), $random(seed), $random(seed) & 1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_xlen(input string name, input string field, input xlen_t exp,
                            input xlen_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sum(input string name, input string field, input sum_t exp,
                           input sum_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input string field, input reg_addr_t exp,
                            input reg_addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input string field, input bit exp,
                            input bit act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", name, field, exp, act);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s latency: expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // driver and collector
  ////////////////////////////////////////////////////////////

  task automatic drive_all();
    foreach (tbl[i]) begin
      @(negedge clk);
      in_valid = 1'b1;
      instr    = tbl[i].instr;
      pc       = tbl[i].pc;
      rs1_val  = tbl[i].rs1;
      rs2_val  = tbl[i].rs2;
      sent_cyc.push_back(cyc);
      repeat (tbl[i].idle) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic collect_all();
    int waited;
    foreach (tbl[i]) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!out_valid && (waited < TIMEOUT));
      if (!out_valid) begin
        $display("timeout: no out_valid for %s within %0d cycles", names[i], TIMEOUT);
        abort_run();
      end
      check_latency(names[i], 2, cyc - sent_cyc[i]);   // issue plus result stage
      check_addr(names[i], "rd_addr", tbl[i].instr[11:7], out_rd_addr);
      check_flag(names[i], "illegal", tbl[i].exp_ill, out_illegal);
      check_flag(names[i], "wen", tbl[i].exp_wen, out_wen);
      if (!tbl[i].exp_ill) begin   // illegal rd/sum undefined
        check_xlen(names[i], "rd", tbl[i].exp_rd, out_rd);
        check_sum(names[i], "sum", tbl[i].exp_sum, out_sum);
      end
    end
  endtask

  initial begin
    seed     = 32'hba2f_113b;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    pc       = '0;
    rs1_val  = '0;
    rs2_val  = '0;
    prev_wen = 1'b0;
    prev_rd  = '0;
    prev_val = '0;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // quiet until the first input
    repeat (3) begin
      @(negedge clk);
      check_flag("after reset", "out_valid", 1'b0, out_valid);
    end
    fork
      drive_all();
      collect_all();
    join
    repeat (4) begin
      @(negedge clk);
      check_flag("drain", "out_valid", 1'b0, out_valid);
    end
    if (DUT.u_props.fail_cnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("a bound assertion on rv_exec_top failed");
      abort_run();
    end
  end

endmodule

`default_nettype wire
